/* Bender.yml */
package:
  name: emu_stim

dependencies: {}

sources:
  - hw/prbs_pkg.sv
  - hw/emu_pkg.sv
  - hw/prbs_generator.sv
  - hw/prbs_lane_bank.sv
  - hw/prbs_lockstep_checker.sv
  - hw/cfg_port.sv
  - hw/emu_stim_top.sv
  - target: simulation
    files:
      - sim/emu_stim_checker.sv
      - sim/tb_emu_stim.sv

/* hw/cfg_port.sv */
`timescale 1ns/1ps

module cfg_port import emu_pkg::*, prbs_pkg::*; (
    input  logic      emu_clk,
    input  logic      emu_rst,

    // Four-phase request side
    input  logic      cfg_req_i,
    input  logic      cfg_we_i,
    input  cfg_addr_t cfg_addr_i,
    input  cfg_data_t cfg_wdata_i,
    output logic      cfg_ack_o,
    output cfg_data_t cfg_rdata_o,

    // Counter readback
    input  count_t    err_count_i,
    input  count_t    step_count_i,

    // Control out to bank and checker
    output logic      run_o,
    output prbs_eqn_t eqn_o,
    output logic      inject_o,
    output logic      err_clr_o
);

    cfg_state_t state;
    logic       accept;
    cfg_data_t  rd_mux;

    //////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////

    // Access happens on the edge that raises the acknowledge
    assign accept = (state == IDLE) && cfg_req_i;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cfg_req_i) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    // Request may already be gone after one cycle
                    state <= cfg_req_i ? WAIT_LOW : IDLE;
                end
                WAIT_LOW: begin
                    if (!cfg_req_i) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign cfg_ack_o = (state != IDLE);

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////

    always_comb begin
        case (cfg_addr_i)
            ADDR_EQN:   rd_mux = cfg_data_t'(eqn_o);
            ADDR_CTRL:  rd_mux = {31'd0, run_o};
            ADDR_ERRS:  rd_mux = cfg_data_t'(err_count_i);
            default:    rd_mux = cfg_data_t'(step_count_i);
        endcase
    end

    // Held for the whole acknowledge phase
    always_ff @(posedge emu_clk) begin
        if (accept && !cfg_we_i) begin
            cfg_rdata_o <= rd_mux;
        end
    end

    //////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            run_o     <= 1'b0;
            eqn_o     <= PRBS_EQN_DEFAULT;
            inject_o  <= 1'b0;
            err_clr_o <= 1'b0;
        end else begin
            // Pulses default low
            inject_o  <= 1'b0;
            err_clr_o <= 1'b0;
            if (accept && cfg_we_i) begin
                case (cfg_addr_i)
                    ADDR_EQN: begin
                        // Equation is locked while running
                        if (!run_o) begin
                            eqn_o <= prbs_eqn_t'(cfg_wdata_i);
                        end
                    end
                    ADDR_CTRL: begin
                        run_o    <= cfg_wdata_i[0];
                        inject_o <= cfg_wdata_i[1];
                    end
                    ADDR_ERRS: begin
                        err_clr_o <= 1'b1;
                    end
                    default: begin
                        // Step count is read only
                    end
                endcase
            end
        end
    end

endmodule

/* hw/emu_pkg.sv */
package emu_pkg;

    //////////////////////////////////////////////////
    // Configuration port types
    //////////////////////////////////////////////////

    typedef logic [1:0]  cfg_addr_t;
    typedef logic [31:0] cfg_data_t;

    // Error and step counters
    typedef logic [31:0] count_t;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    localparam cfg_addr_t ADDR_EQN   = 2'd0;
    // Bit 0 run, bit 1 inject
    localparam cfg_addr_t ADDR_CTRL  = 2'd1;
    // Read error count, write clears it
    localparam cfg_addr_t ADDR_ERRS  = 2'd2;
    localparam cfg_addr_t ADDR_STEPS = 2'd3;

    //////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_LOW
    } cfg_state_t;

endpackage

/* hw/emu_stim_top.sv */
`timescale 1ns/1ps

module emu_stim_top import emu_pkg::*, prbs_pkg::*; #(
    parameter int NTI        = 16,
    parameter int NUM_CHUNKS = 4
) (
    input  logic           emu_clk,
    input  logic           emu_rst,

    input  logic           cfg_req_i,
    input  logic           cfg_we_i,
    input  cfg_addr_t      cfg_addr_i,
    input  cfg_data_t      cfg_wdata_i,
    output logic           cfg_ack_o,
    output cfg_data_t      cfg_rdata_o,

    output logic [NTI-1:0] rx_data_o,
    output logic           rx_valid_o
);

    logic      run;
    prbs_eqn_t eqn;
    logic      inject_pulse;
    logic      err_clr;
    count_t    err_count;
    count_t    step_count;

    //////////////////////////////////////////////////
    // Register port
    //////////////////////////////////////////////////

    cfg_port u_cfg (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .cfg_req_i    (cfg_req_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_ack_o    (cfg_ack_o),
        .cfg_rdata_o  (cfg_rdata_o),
        .err_count_i  (err_count),
        .step_count_i (step_count),
        .run_o        (run),
        .eqn_o        (eqn),
        .inject_o     (inject_pulse),
        .err_clr_o    (err_clr)
    );

    //////////////////////////////////////////////////
    // Stimulus and checking
    //////////////////////////////////////////////////

    prbs_lane_bank #(
        .NTI        (NTI),
        .NUM_CHUNKS (NUM_CHUNKS)
    ) u_bank (
        .emu_clk    (emu_clk),
        .emu_rst    (emu_rst),
        .run_i      (run),
        .eqn_i      (eqn),
        .inject_i   (inject_pulse),
        .rx_data_o  (rx_data_o),
        .rx_valid_o (rx_valid_o)
    );

    prbs_lockstep_checker #(
        .NTI (NTI)
    ) u_check (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .run_i        (run),
        .eqn_i        (eqn),
        .rx_data_i    (rx_data_o),
        .rx_valid_i   (rx_valid_o),
        .err_clr_i    (err_clr),
        .err_count_o  (err_count),
        .step_count_o (step_count)
    );

endmodule

/* hw/prbs_generator.sv */
`timescale 1ns/1ps

module prbs_generator import prbs_pkg::*; (
    input  logic        emu_clk,
    input  logic        emu_rst,
    input  logic        cke_i,
    input  logic        reseed_i,
    input  prbs_state_t seed_i,
    input  prbs_eqn_t   eqn_i,
    input  logic        inj_err_i,
    output logic        bit_o
);

    //////////////////////////////////////////////////
    // Shift register
    //////////////////////////////////////////////////

    prbs_state_t state;
    logic        feedback;

    // Parity over the tapped bits
    assign feedback = ^(state & eqn_i);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            state <= seed_i;
        end else if (reseed_i) begin
            // Reseed wins over a step
            state <= seed_i;
        end else if (cke_i) begin
            state <= {state[N_PRBS-2:0], feedback};
        end
    end

    //////////////////////////////////////////////////
    // Output
    //////////////////////////////////////////////////

    // Injection flips only the output, the sequence itself continues
    assign bit_o = state[N_PRBS-1] ^ inj_err_i;

endmodule

/* hw/prbs_lane_bank.sv */
`timescale 1ns/1ps

module prbs_lane_bank import prbs_pkg::*; #(
    parameter int NTI        = 16,
    parameter int NUM_CHUNKS = 4
) (
    input  logic           emu_clk,
    input  logic           emu_rst,
    input  logic           run_i,
    input  prbs_eqn_t      eqn_i,
    input  logic           inject_i,
    output logic [NTI-1:0] rx_data_o,
    output logic           rx_valid_o
);

    localparam int CNT_W = $clog2(NUM_CHUNKS + 2);

    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [NTI-1:0]   rx_word_t;

    localparam cnt_t CNT_LAST = cnt_t'(NUM_CHUNKS + 1);

    cnt_t      counter;
    logic      prbs_cke;
    logic      valid_q;
    logic      inj_pend;
    logic      inj_active;
    prbs_eqn_t eqn_q;
    rx_word_t  lane_bits;

    //////////////////////////////////////////////////
    // Cadence counter
    //////////////////////////////////////////////////

    assign prbs_cke = run_i && (counter == CNT_LAST);

    always_ff @(posedge emu_clk) begin
        if (emu_rst || !run_i) begin
            counter <= '0;
        end else if (counter == CNT_LAST) begin
            counter <= '0;
        end else begin
            counter <= counter + cnt_t'(1);
        end
    end

    // Strobe follows the step by one clock
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= prbs_cke;
        end
    end

    // A step taken just as run drops is not presented
    assign rx_valid_o = valid_q & run_i;

    // Equation only follows the register while stopped
    always_ff @(posedge emu_clk) begin
        if (!run_i) begin
            eqn_q <= eqn_i;
        end
    end

    //////////////////////////////////////////////////
    // Error injection
    //////////////////////////////////////////////////

    // Request waits for the next step, then covers that one word
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            inj_pend   <= 1'b0;
            inj_active <= 1'b0;
        end else if (prbs_cke) begin
            inj_pend   <= 1'b0;
            inj_active <= inj_pend | inject_i;
        end else begin
            inj_pend <= inj_pend | inject_i;
        end
    end

    //////////////////////////////////////////////////
    // Lanes
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NTI; i++) begin : g_lane
        prbs_generator u_gen (
            .emu_clk   (emu_clk),
            .emu_rst   (emu_rst),
            .cke_i     (prbs_cke),
            .reseed_i  (!run_i),
            .seed_i    (prbs_state_t'(i + 1)),
            .eqn_i     (eqn_q),
            .inj_err_i ((i == 0) ? inj_active : 1'b0),
            .bit_o     (lane_bits[i])
        );
    end

    assign rx_data_o = lane_bits;

endmodule

/* hw/prbs_lockstep_checker.sv */
`timescale 1ns/1ps

module prbs_lockstep_checker import emu_pkg::*, prbs_pkg::*; #(
    parameter int NTI = 16
) (
    input  logic           emu_clk,
    input  logic           emu_rst,
    input  logic           run_i,
    input  prbs_eqn_t      eqn_i,
    input  logic [NTI-1:0] rx_data_i,
    input  logic           rx_valid_i,
    input  logic           err_clr_i,
    output count_t         err_count_o,
    output count_t         step_count_o
);

    typedef logic [NTI-1:0] rx_word_t;

    prbs_eqn_t eqn_q;
    rx_word_t  expected;
    rx_word_t  word_q;
    rx_word_t  diff;
    logic      cmp_q;
    logic      run_q;
    count_t    mism_bits;

    //////////////////////////////////////////////////
    // Reference generators
    //////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (!run_i) begin
            eqn_q <= eqn_i;
        end
    end

    // Stepping on the strobe keeps these one step behind the bank,
    // so they show the expected word the clock after valid
    for (genvar i = 0; i < NTI; i++) begin : g_ref
        prbs_generator u_ref (
            .emu_clk   (emu_clk),
            .emu_rst   (emu_rst),
            .cke_i     (rx_valid_i),
            .reseed_i  (!run_i),
            .seed_i    (prbs_state_t'(i + 1)),
            .eqn_i     (eqn_q),
            .inj_err_i (1'b0),
            .bit_o     (expected[i])
        );
    end

    //////////////////////////////////////////////////
    // Capture and compare
    //////////////////////////////////////////////////

    // Received word, sampled on the strobe
    always_ff @(posedge emu_clk) begin
        if (rx_valid_i) begin
            word_q <= rx_data_i;
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            cmp_q <= 1'b0;
            run_q <= 1'b0;
        end else begin
            cmp_q <= rx_valid_i;
            run_q <= run_i;
        end
    end

    assign diff = word_q ^ expected;

    // Population count of the mismatch vector
    always_comb begin
        mism_bits = '0;
        for (int i = 0; i < NTI; i++) begin
            mism_bits = mism_bits + count_t'(diff[i]);
        end
    end

    //////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst || err_clr_i) begin
            err_count_o <= '0;
        end else if (cmp_q) begin
            err_count_o <= err_count_o + mism_bits;
        end
    end

    // Step count restarts with each run
    always_ff @(posedge emu_clk) begin
        if (emu_rst || (run_i && !run_q)) begin
            step_count_o <= '0;
        end else if (cmp_q) begin
            step_count_o <= step_count_o + count_t'(1);
        end
    end

endmodule

/* hw/prbs_pkg.sv */
package prbs_pkg;

    //////////////////////////////////////////////////
    // LFSR geometry
    //////////////////////////////////////////////////

    // Length of every lane's shift register
    localparam int N_PRBS = 32;

    // Raw LFSR contents, bit N_PRBS-1 is the output bit
    typedef logic [N_PRBS-1:0] prbs_state_t;

    // Feedback mask, bit k set means state bit k enters the parity
    typedef logic [N_PRBS-1:0] prbs_eqn_t;

    //////////////////////////////////////////////////
    // Default equation
    //////////////////////////////////////////////////

    // x^31 + x^28 + 1, taps on state bits 30 and 27
    localparam prbs_eqn_t PRBS_EQN_DEFAULT = prbs_eqn_t'(32'h4800_0000);

endpackage

/* sim/emu_stim_checker.sv */
`timescale 1ns/1ps

module emu_stim_checker #(
    parameter int NUM_CHUNKS = 4
) (
    input  logic emu_clk,
    input  logic emu_rst,
    input  logic cfg_req_i,
    input  logic cfg_ack_i,
    input  logic run_i,
    input  logic rx_valid_i
);

    // Quiet clocks between two strobes
    localparam int GAP = NUM_CHUNKS + 1;

    int assert_fails = 0;

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    ack_follows_req: assert property (@(posedge emu_clk) disable iff (emu_rst)
        $rose(cfg_ack_i) |-> $past(cfg_req_i))
        else begin
            assert_fails++;
            $error("cfg_ack_o rose without a pending request");
        end

    //////////////////////////////////////////////////
    // Strobe timing
    //////////////////////////////////////////////////

    valid_single: assert property (@(posedge emu_clk) disable iff (emu_rst)
        rx_valid_i |=> !rx_valid_i)
        else begin
            assert_fails++;
            $error("rx_valid_o was high for more than one clock");
        end

    // Cancelled as soon as run drops
    valid_spacing: assert property (@(posedge emu_clk) disable iff (emu_rst || !run_i)
        rx_valid_i |=> (!rx_valid_i [*GAP]) ##1 rx_valid_i)
        else begin
            assert_fails++;
            $error("rx_valid_o pulses not spaced NUM_CHUNKS+2 clocks apart");
        end

    // Run must also have been high on the step clock
    valid_needs_run: assert property (@(posedge emu_clk) disable iff (emu_rst)
        $rose(rx_valid_i) |-> run_i && $past(run_i))
        else begin
            assert_fails++;
            $error("rx_valid_o rose while run was low");
        end

endmodule

/* sim/tb_emu_stim.sv */
`timescale 1ns/1ps

module tb_emu_stim import emu_pkg::*, prbs_pkg::*;;

    localparam int NTI        = 16;
    localparam int NUM_CHUNKS = 4;
    localparam int CLK_PERIOD = 40;
    localparam int ACK_LIMIT  = 16;

    // Words checked in each phase
    localparam int STEPS_RUN     = 200;
    localparam int STEPS_EQN     = 100;
    localparam int STEPS_LOCKED  = 50;
    localparam int STEPS_INJ_MAX = 4;
    localparam int STEPS_INJ     = 20;
    localparam int STEPS_CLR     = 30;
    localparam int STEPS_RESTART = 60;
    localparam int TOTAL_STEPS   = STEPS_RUN + STEPS_EQN + STEPS_LOCKED + STEPS_INJ_MAX
                                   + STEPS_INJ + STEPS_CLR + STEPS_RESTART;
    localparam int N_TRANSACTIONS = 50;
    localparam longint WATCHDOG_NS = longint'(TOTAL_STEPS + N_TRANSACTIONS)
                                     * (NUM_CHUNKS + 2) * CLK_PERIOD * 2;

    typedef logic [NTI-1:0] rx_word_t;

    logic      emu_clk;
    logic      emu_rst;
    logic      cfg_req;
    logic      cfg_we;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_wdata;
    logic      cfg_ack;
    cfg_data_t cfg_rdata;
    rx_word_t  rx_data;
    logic      rx_valid;

    // Reference lanes
    prbs_state_t model_state [NTI];
    prbs_eqn_t   model_eqn = PRBS_EQN_DEFAULT;
    rx_word_t    exp_word;
    rx_word_t    diff_word;

    int   words_seen   = 0;
    int   words_total  = 0;
    int   inj_seen     = 0;
    logic inj_expected = 1'b0;
    int   word_errs    = 0;
    int   count_errs   = 0;
    int   data_errs    = 0;
    int   other_errs   = 0;
    integer seed       = 45;

    emu_stim_top UUT (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .cfg_req_i   (cfg_req),
        .cfg_we_i    (cfg_we),
        .cfg_addr_i  (cfg_addr),
        .cfg_wdata_i (cfg_wdata),
        .cfg_ack_o   (cfg_ack),
        .cfg_rdata_o (cfg_rdata),
        .rx_data_o   (rx_data),
        .rx_valid_o  (rx_valid)
    );

    bind emu_stim_top emu_stim_checker #(.NUM_CHUNKS(NUM_CHUNKS)) u_checker (
        .emu_clk    (emu_clk),
        .emu_rst    (emu_rst),
        .cfg_req_i  (cfg_req_i),
        .cfg_ack_i  (cfg_ack_o),
        .run_i      (run),
        .rx_valid_i (rx_valid_o)
    );

    initial begin
        emu_clk = 1'b0;
        forever #(CLK_PERIOD / 2) emu_clk = ~emu_clk;
    end

    //////////////////////////////////////////////////
    // Reference model and compare tasks
    //////////////////////////////////////////////////

    // Shift left and feed the parity of the tapped bits into bit 0
    function automatic prbs_state_t lfsr_step(prbs_state_t s, prbs_eqn_t e);
        return {s[N_PRBS-2:0], ^(s & e)};
    endfunction

    task automatic reseed_models();
        for (int i = 0; i < NTI; i++) begin
            model_state[i] = prbs_state_t'(i + 1);
        end
    endtask

    task automatic check_word(input string name, input rx_word_t got, input rx_word_t exp);
        if (got !== exp) begin
            word_errs++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            count_errs++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input cfg_data_t got, input cfg_data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // Every strobe steps the model
    // Lane 0 alone may differ once after inject
    always @(negedge emu_clk) begin
        if (!emu_rst && rx_valid) begin
            for (int i = 0; i < NTI; i++) begin
                model_state[i] = lfsr_step(model_state[i], model_eqn);
                exp_word[i]    = model_state[i][N_PRBS-1];
            end
            diff_word = rx_data ^ exp_word;
            if (inj_expected && diff_word == rx_word_t'(1)) begin
                inj_expected = 1'b0;
                inj_seen++;
            end else begin
                check_word("rx_data_o", rx_data, exp_word);
            end
            words_seen++;
            words_total++;
        end
    end

    //////////////////////////////////////////////////
    // Register access
    //////////////////////////////////////////////////

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        @(negedge emu_clk);
        while (cfg_ack !== level && cycles < ACK_LIMIT) begin
            @(negedge emu_clk);
            cycles++;
        end
        if (cfg_ack !== level) begin
            other_errs++;
            $display("Handshake error: cfg_ack_o never went to %0b", level);
        end
    endtask

    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
        @(negedge emu_clk);
        cfg_req   = 1'b1;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        wait_ack(1'b1);
        cfg_req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic read_reg(input cfg_addr_t addr, output cfg_data_t data);
        @(negedge emu_clk);
        cfg_req  = 1'b1;
        cfg_we   = 1'b0;
        cfg_addr = addr;
        wait_ack(1'b1);
        data    = cfg_rdata;
        cfg_req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic read_count(input cfg_addr_t addr, input count_t exp, input string name);
        cfg_data_t data;
        read_reg(addr, data);
        check_count(name, count_t'(data), exp);
    endtask

    task automatic read_data(input cfg_addr_t addr, input cfg_data_t exp, input string name);
        cfg_data_t data;
        read_reg(addr, data);
        check_data(name, data, exp);
    endtask

    task automatic wait_words(input int n);
        int target;
        target = words_seen + n;
        while (words_seen < target) begin
            @(negedge emu_clk);
        end
    endtask

    task automatic start_run();
        reseed_models();
        words_seen = 0;
        write_reg(ADDR_CTRL, 32'd1);
    endtask

    task automatic stop_run();
        write_reg(ADDR_CTRL, 32'd0);
        repeat (4) @(negedge emu_clk);
    endtask

    task automatic print_summary();
        $display("Summary: %0d word, %0d count, %0d data, %0d other, %0d assertion errors",
                 word_errs, count_errs, data_errs, other_errs, UUT.u_checker.assert_fails);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin : main
        cfg_data_t eqn_a;
        cfg_data_t eqn_b;
        cfg_data_t rdata;
        int        total_mark;
        int        waited;
        emu_rst   = 1'b1;
        cfg_req   = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = ADDR_EQN;
        cfg_wdata = '0;
        reseed_models();
        repeat (3) @(negedge emu_clk);
        emu_rst = 1'b0;

        // Reset values and no strobe while stopped
        read_data(ADDR_EQN, cfg_data_t'(PRBS_EQN_DEFAULT), "eqn after reset");
        read_data(ADDR_CTRL, 32'd0, "ctrl after reset");
        read_count(ADDR_ERRS, 0, "err count after reset");
        read_count(ADDR_STEPS, 0, "step count after reset");
        repeat (3 * (NUM_CHUNKS + 2)) @(negedge emu_clk);
        if (words_total != 0) begin
            other_errs++;
            $display("rx_valid_o pulsed before run was set");
        end

        // Default equation run
        start_run();
        read_data(ADDR_CTRL, 32'd1, "ctrl while running");
        wait_words(STEPS_RUN);
        stop_run();
        read_count(ADDR_ERRS, 0, "err count after first run");
        read_count(ADDR_STEPS, count_t'(words_seen), "step count after first run");

        // New equation and then a write that must be ignored
        eqn_a = $random(seed) | 32'h4000_0000;
        write_reg(ADDR_EQN, eqn_a);
        read_data(ADDR_EQN, eqn_a, "eqn while stopped");
        model_eqn = prbs_eqn_t'(eqn_a);
        start_run();
        wait_words(STEPS_EQN);
        eqn_b = $random(seed) | 32'h4000_0000;
        write_reg(ADDR_EQN, eqn_b);
        read_data(ADDR_EQN, eqn_a, "eqn after locked write");
        wait_words(STEPS_LOCKED);

        // Single bit error on lane 0
        read_reg(ADDR_ERRS, rdata);
        check_count("err count before inject", count_t'(rdata), 0);
        inj_expected = 1'b1;
        write_reg(ADDR_CTRL, 32'd3);
        waited = 0;
        while (inj_seen == 0 && waited < STEPS_INJ_MAX) begin
            wait_words(1);
            waited++;
        end
        if (inj_seen != 1) begin
            other_errs++;
            $display("Injected error word not seen within %0d words of the request",
                     STEPS_INJ_MAX);
        end
        wait_words(STEPS_INJ);
        read_count(ADDR_ERRS, count_t'(1), "err count after inject");

        // Clear errors while steps keep going
        write_reg(ADDR_ERRS, 32'd0);
        read_count(ADDR_ERRS, 0, "err count after clear");
        wait_words(STEPS_CLR);
        stop_run();
        read_count(ADDR_STEPS, count_t'(words_seen), "step count across clear");
        read_count(ADDR_ERRS, 0, "err count after clear run");

        // Stopped means silent and restart begins again at seeds i+1
        total_mark = words_total;
        repeat (3 * (NUM_CHUNKS + 2)) @(negedge emu_clk);
        if (words_total != total_mark) begin
            other_errs++;
            $display("rx_valid_o pulsed after run was cleared");
        end
        read_data(ADDR_CTRL, 32'd0, "ctrl after stop");
        start_run();
        wait_words(STEPS_RESTART);
        stop_run();
        read_count(ADDR_STEPS, count_t'(words_seen), "step count after restart");
        read_count(ADDR_ERRS, 0, "err count after restart");

        print_summary();
        if (word_errs + count_errs + data_errs + other_errs + UUT.u_checker.assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        print_summary();
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* src.f */
hw/prbs_pkg.sv
hw/emu_pkg.sv
hw/prbs_generator.sv
hw/prbs_lane_bank.sv
hw/prbs_lockstep_checker.sv
hw/cfg_port.sv
hw/emu_stim_top.sv
sim/emu_stim_checker.sv
sim/tb_emu_stim.sv
